// ==== memPkg.sv ====
`default_nettype none

package memPkg;

    // Datapath and address width
    localparam int DATA_WIDTH = 32;

    // Byte lanes per data word
    localparam int BYTE_LANES = DATA_WIDTH / 8;

    // Data RAM geometry
    localparam int RAM_WORDS       = 256;
    localparam int WORD_ADDR_WIDTH = 8;

    // Memory operation, same encoding as funct3 of loads and stores
    typedef enum logic [2:0] {
        OP_BYTE   = 3'b000,
        OP_HALF   = 3'b001,
        OP_WORD   = 3'b010,
        OP_BYTE_U = 3'b100,
        OP_HALF_U = 3'b101
    } memOp_e;

    // Writeback result source
    typedef enum logic [1:0] {
        RESULT_ALU = 2'b00,
        RESULT_MEM = 2'b01,
        RESULT_PC4 = 2'b10
    } resultSrc_e;

endpackage

`default_nettype wire

// ==== memPort_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface memPort_if;

    // One data RAM access per cycle
    logic [memPkg::WORD_ADDR_WIDTH-1:0] wordAddr;
    logic [1:0]                         byteOffset;
    logic [memPkg::BYTE_LANES-1:0]      byteEn;
    logic                               writeEn;
    logic [memPkg::DATA_WIDTH-1:0]      writeData;
    logic [memPkg::DATA_WIDTH-1:0]      readWord;

    modport formatter (
        output wordAddr,
        output byteOffset,
        output byteEn,
        output writeEn,
        output writeData
    );

    modport ram (
        input  wordAddr,
        input  byteEn,
        input  writeEn,
        input  writeData,
        output readWord
    );

    modport aligner (
        input  byteOffset,
        input  readWord
    );

endinterface

`default_nettype wire

// ==== storeFormatter.sv ====
`timescale 1ns/10ps
`default_nettype none

module storeFormatter (
    input  logic                          memWrite_i,
    input  memPkg::memOp_e                memoryOp_i,
    input  logic [memPkg::DATA_WIDTH-1:0] address_i,
    input  logic [memPkg::DATA_WIDTH-1:0] storeData_i,
    memPort_if.formatter                  mem
);

    logic [1:0] offset;

    assign offset = address_i[1:0];

    // Word index drops the two byte-select bits
    assign mem.wordAddr   = address_i[memPkg::WORD_ADDR_WIDTH+1:2];
    assign mem.byteOffset = offset;
    assign mem.writeEn    = memWrite_i;

    // Lane enables and replicated write data
    always_comb begin
        unique case (memoryOp_i)
            memPkg::OP_BYTE,
            memPkg::OP_BYTE_U: begin
                mem.byteEn    = 4'b0001 << offset;
                mem.writeData = {4{storeData_i[7:0]}};
            end
            memPkg::OP_HALF,
            memPkg::OP_HALF_U: begin
                // Offset bit 0 ignored for halfwords
                if (offset[1]) begin
                    mem.byteEn = 4'b1100;
                end else begin
                    mem.byteEn = 4'b0011;
                end
                mem.writeData = {2{storeData_i[15:0]}};
            end
            memPkg::OP_WORD: begin
                mem.byteEn    = 4'b1111;
                mem.writeData = storeData_i;
            end
            default: begin
                mem.byteEn    = 4'b0000;
                mem.writeData = storeData_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== dataRam.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataRam (
    input  logic clk,
    memPort_if.ram mem
);

    // Word storage, contents undefined until written
    logic [memPkg::DATA_WIDTH-1:0] ramArray [memPkg::RAM_WORDS];

    // Per-lane write at the rising edge
    always_ff @(posedge clk) begin
        if (mem.writeEn) begin
            for (int lane = 0; lane < memPkg::BYTE_LANES; lane++) begin
                if (mem.byteEn[lane]) begin
                    ramArray[mem.wordAddr][lane*8 +: 8] <= mem.writeData[lane*8 +: 8];
                end
            end
        end
    end

    // Asynchronous read, new data visible the cycle after a store
    assign mem.readWord = ramArray[mem.wordAddr];

endmodule

`default_nettype wire

// ==== loadAligner.sv ====
`timescale 1ns/10ps
`default_nettype none

module loadAligner (
    input  memPkg::memOp_e                memoryOp_i,
    memPort_if.aligner                    mem,
    output logic [memPkg::DATA_WIDTH-1:0] loadData_o
);

    logic [1:0]                    effOffset;
    logic [memPkg::DATA_WIDTH-1:0] shiftedWord;

    // Ignore offset bits below the access size
    always_comb begin
        unique case (memoryOp_i)
            memPkg::OP_BYTE,
            memPkg::OP_BYTE_U: effOffset = mem.byteOffset;
            memPkg::OP_HALF,
            memPkg::OP_HALF_U: effOffset = {mem.byteOffset[1], 1'b0};
            default:           effOffset = 2'b00;
        endcase
    end

    // Addressed lane moved down to bit 0
    assign shiftedWord = mem.readWord >> {effOffset, 3'b000};

    // Sign or zero extension
    always_comb begin
        unique case (memoryOp_i)
            memPkg::OP_BYTE:
                loadData_o = {{(memPkg::DATA_WIDTH-8){shiftedWord[7]}}, shiftedWord[7:0]};
            memPkg::OP_BYTE_U:
                loadData_o = {{(memPkg::DATA_WIDTH-8){1'b0}}, shiftedWord[7:0]};
            memPkg::OP_HALF:
                loadData_o = {{(memPkg::DATA_WIDTH-16){shiftedWord[15]}}, shiftedWord[15:0]};
            memPkg::OP_HALF_U:
                loadData_o = {{(memPkg::DATA_WIDTH-16){1'b0}}, shiftedWord[15:0]};
            default:
                loadData_o = shiftedWord;
        endcase
    end

endmodule

`default_nettype wire

// ==== writebackRegister.sv ====
`timescale 1ns/10ps
`default_nettype none

module writebackRegister (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          stall_i,

    input  logic                          regWrite_i,
    input  memPkg::resultSrc_e            resultSrc_i,
    input  logic [memPkg::DATA_WIDTH-1:0] aluResult_i,
    input  logic [memPkg::DATA_WIDTH-1:0] loadData_i,
    input  logic [4:0]                    rd_i,
    input  logic [memPkg::DATA_WIDTH-1:0] pcPlus4_i,

    output logic                          regWrite_o,
    output logic [4:0]                    rd_o,
    output logic [memPkg::DATA_WIDTH-1:0] result_o
);

    logic                          regWriteW;
    memPkg::resultSrc_e            resultSrcW;
    logic [memPkg::DATA_WIDTH-1:0] aluResultW;
    logic [memPkg::DATA_WIDTH-1:0] loadDataW;
    logic [4:0]                    rdW;
    logic [memPkg::DATA_WIDTH-1:0] pcPlus4W;

    // M to W pipeline register, held while stalled
    always_ff @(posedge clk) begin
        if (reset_i) begin
            regWriteW  <= 1'b0;
            resultSrcW <= memPkg::RESULT_ALU;
            aluResultW <= '0;
            loadDataW  <= '0;
            rdW        <= '0;
            pcPlus4W   <= '0;
        end else if (!stall_i) begin
            regWriteW  <= regWrite_i;
            resultSrcW <= resultSrc_i;
            aluResultW <= aluResult_i;
            loadDataW  <= loadData_i;
            rdW        <= rd_i;
            pcPlus4W   <= pcPlus4_i;
        end
    end

    assign regWrite_o = regWriteW;
    assign rd_o       = rdW;

    // Final result select
    always_comb begin
        unique case (resultSrcW)
            memPkg::RESULT_ALU: result_o = aluResultW;
            memPkg::RESULT_MEM: result_o = loadDataW;
            memPkg::RESULT_PC4: result_o = pcPlus4W;
            default:            result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== memStageTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module memStageTop (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          stall_i,

    input  logic                          regWriteM_i,
    input  memPkg::resultSrc_e            resultSrcM_i,
    input  logic                          memWriteM_i,
    input  memPkg::memOp_e                memoryOpM_i,
    input  logic [memPkg::DATA_WIDTH-1:0] aluResultM_i,
    input  logic [memPkg::DATA_WIDTH-1:0] writeDataM_i,
    input  logic [4:0]                    rdM_i,
    input  logic [memPkg::DATA_WIDTH-1:0] pcPlus4M_i,

    // Aligned load value, fed back for forwarding
    output logic [memPkg::DATA_WIDTH-1:0] readDataM_o,

    output logic                          regWriteW_o,
    output logic [4:0]                    rdW_o,
    output logic [memPkg::DATA_WIDTH-1:0] resultW_o
);

    memPort_if memBus ();

    // Store side
    storeFormatter formatter (
        .memWrite_i  (memWriteM_i),
        .memoryOp_i  (memoryOpM_i),
        .address_i   (aluResultM_i),
        .storeData_i (writeDataM_i),
        .mem         (memBus.formatter)
    );

    dataRam ram (
        .clk (clk),
        .mem (memBus.ram)
    );

    // Load side
    loadAligner aligner (
        .memoryOp_i (memoryOpM_i),
        .mem        (memBus.aligner),
        .loadData_o (readDataM_o)
    );

    writebackRegister wbReg (
        .clk         (clk),
        .reset_i     (reset_i),
        .stall_i     (stall_i),
        .regWrite_i  (regWriteM_i),
        .resultSrc_i (resultSrcM_i),
        .aluResult_i (aluResultM_i),
        .loadData_i  (readDataM_o),
        .rd_i        (rdM_i),
        .pcPlus4_i   (pcPlus4M_i),
        .regWrite_o  (regWriteW_o),
        .rd_o        (rdW_o),
        .result_o    (resultW_o)
    );

endmodule

`default_nettype wire

// ==== tb_memStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_memStage;

    localparam int TRACE_LINES  = 34;
    localparam int LINE_BITS    = 204;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + TRACE_LINES + 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int SAMPLE_DELAY = 36;

    logic                          clk;
    logic                          reset;
    logic                          stall;
    logic                          regWriteM;
    memPkg::resultSrc_e            resultSrcM;
    logic                          memWriteM;
    memPkg::memOp_e                memoryOpM;
    logic [memPkg::DATA_WIDTH-1:0] aluResultM;
    logic [memPkg::DATA_WIDTH-1:0] writeDataM;
    logic [4:0]                    rdM;
    logic [memPkg::DATA_WIDTH-1:0] pcPlus4M;

    logic [memPkg::DATA_WIDTH-1:0] readDataM;
    logic                          regWriteW;
    logic [4:0]                    rdW;
    logic [memPkg::DATA_WIDTH-1:0] resultW;

    // One hex digit per flag in each trace line
    logic [LINE_BITS-1:0] traceMem [TRACE_LINES];

    int cycleCount = 0;

    memStageTop i_dut (
        .clk          (clk),
        .reset_i      (reset),
        .stall_i      (stall),
        .regWriteM_i  (regWriteM),
        .resultSrcM_i (resultSrcM),
        .memWriteM_i  (memWriteM),
        .memoryOpM_i  (memoryOpM),
        .aluResultM_i (aluResultM),
        .writeDataM_i (writeDataM),
        .rdM_i        (rdM),
        .pcPlus4M_i   (pcPlus4M),
        .readDataM_o  (readDataM),
        .regWriteW_o  (regWriteW),
        .rdW_o        (rdW),
        .resultW_o    (resultW)
    );

    always #20 clk = ~clk;

    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkValue(input string testName,
                              input logic [memPkg::DATA_WIDTH-1:0] expected,
                              input logic [memPkg::DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            reportFailure($sformatf("mismatch %s expected %h actual %h",
                                    testName, expected, actual));
        end
    endtask

    task automatic checkWriteback(input string testName,
                                  input logic expRegWrite,
                                  input logic [4:0] expRd,
                                  input logic [memPkg::DATA_WIDTH-1:0] expResult);
        checkValue({testName, " regWriteW"},
                   {{(memPkg::DATA_WIDTH-1){1'b0}}, expRegWrite},
                   {{(memPkg::DATA_WIDTH-1){1'b0}}, regWriteW});
        checkValue({testName, " rdW"},
                   {{(memPkg::DATA_WIDTH-5){1'b0}}, expRd},
                   {{(memPkg::DATA_WIDTH-5){1'b0}}, rdW});
        checkValue({testName, " resultW"}, expResult, resultW);
    endtask

    // Unpack the stimulus digits of one trace line
    task automatic applyLine(input logic [LINE_BITS-1:0] line);
        stall      = line[200];
        regWriteM  = line[196];
        resultSrcM = memPkg::resultSrc_e'(line[193:192]);
        memWriteM  = line[188];
        memoryOpM  = memPkg::memOp_e'(line[186:184]);
        aluResultM = line[183:152];
        writeDataM = line[151:120];
        rdM        = line[116:112];
        pcPlus4M   = line[111:80];
    endtask

    task automatic checkLine(input int index, input logic [LINE_BITS-1:0] line);
        string testName;
        testName = $sformatf("line %0d", index);
        // Load value only compared where the addressed word is defined
        if (line[76]) begin
            checkValue({testName, " readDataM"}, line[75:44], readDataM);
        end
        checkWriteback(testName, line[40], line[36:32], line[31:0]);
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            reportFailure("Simulation timed out before the trace ended");
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        stall      = 1'b0;
        // Busy M inputs while reset is held
        regWriteM  = 1'b1;
        resultSrcM = memPkg::RESULT_ALU;
        memWriteM  = 1'b0;
        memoryOpM  = memPkg::OP_WORD;
        aluResultM = 32'h0000_0FFC;
        writeDataM = '0;
        rdM        = 5'h1F;
        pcPlus4M   = '0;

        // All ones marks a line the file did not fill
        for (int i = 0; i < TRACE_LINES; i++) begin
            traceMem[i] = '1;
        end
        $readmemh("memStageTrace.txt", traceMem);
        for (int i = 0; i < TRACE_LINES; i++) begin
            if (traceMem[i] === '1) begin
                reportFailure("The trace file holds fewer lines than the testbench expects");
            end
        end

        // Reset released just after the last reset edge
        for (int r = 1; r <= RESET_CYCLES; r++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (r == RESET_CYCLES) begin
                reset      = 1'b0;
                regWriteM  = 1'b0;
                rdM        = '0;
                aluResultM = '0;
            end
            #SAMPLE_DELAY;
            checkWriteback($sformatf("reset cycle %0d", r), 1'b0, 5'd0, '0);
        end

        // One trace line per cycle
        for (int i = 0; i < TRACE_LINES; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            applyLine(traceMem[i]);
            #SAMPLE_DELAY;
            checkLine(i, traceMem[i]);
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== memStageTrace.txt ====
// stall_regWrite_resultSrc_memWrite_memOp_aluResult_writeData_rd_pcPlus4_
// checkRead_expReadData_expRegWriteW_expRdW_expResultW (W fields are from the previous edge)
0_0_0_1_2_00000040_DEADBEEF_00_00000104_0_00000000_0_00_00000000
0_1_1_0_2_00000040_00000000_05_00000108_1_DEADBEEF_0_00_00000040
0_1_0_0_2_12345678_00000000_06_0000010C_0_00000000_1_05_DEADBEEF
0_1_2_0_2_CAFE0000_00000000_01_00000110_0_00000000_1_06_12345678
0_0_0_1_2_00000080_00000000_00_00000114_0_00000000_1_01_00000110
0_0_0_1_0_00000081_000000A5_00_00000118_1_00000000_0_00_00000080
0_0_0_1_1_00000082_0000F00D_00_0000011C_1_00000000_0_00_00000081
0_0_0_1_0_00000080_11223380_00_00000120_1_00000000_0_00_00000082
0_1_1_0_2_00000080_00000000_07_00000124_1_F00DA580_0_00_00000080
0_1_1_0_0_00000080_00000000_08_00000128_1_FFFFFF80_1_07_F00DA580
0_1_1_0_4_00000080_00000000_09_0000012C_1_00000080_1_08_FFFFFF80
0_1_1_0_0_00000081_00000000_0A_00000130_1_FFFFFFA5_1_09_00000080
0_1_1_0_1_00000082_00000000_0B_00000134_1_FFFFF00D_1_0A_FFFFFFA5
0_1_1_0_5_00000082_00000000_0C_00000138_1_0000F00D_1_0B_FFFFF00D
0_1_1_0_1_00000080_00000000_0D_0000013C_1_FFFFA580_1_0C_0000F00D
0_1_1_0_5_00000080_00000000_0E_00000140_1_0000A580_1_0D_FFFFA580
0_1_1_0_4_00000083_00000000_0F_00000144_1_000000F0_1_0E_0000A580
0_1_1_0_0_00000082_00000000_10_00000148_1_0000000D_1_0F_000000F0
0_1_0_0_2_00000055_00000000_11_0000014C_0_00000000_1_10_0000000D
1_1_0_0_2_000000AA_00000000_12_00000150_0_00000000_1_11_00000055
1_0_2_0_2_BBBB0000_00000000_13_00000154_0_00000000_1_11_00000055
1_1_1_0_2_00000040_00000000_14_00000158_1_DEADBEEF_1_11_00000055
0_1_2_0_2_00000077_00000000_15_0000015C_0_00000000_1_11_00000055
0_0_0_0_2_000000C4_00000000_00_00000160_0_00000000_1_15_0000015C
1_0_0_1_2_000000C0_13579BDF_00_00000164_0_00000000_0_00_000000C4
0_1_1_0_2_000000C0_00000000_16_00000168_1_13579BDF_0_00_000000C4
0_0_0_0_2_00000000_00000000_00_0000016C_0_00000000_1_16_13579BDF
0_0_0_1_0_000000C3_00000042_00_00000170_1_00000013_0_00_00000000
0_0_0_1_1_000000C0_00008001_00_00000174_1_FFFF9BDF_0_00_000000C3
0_1_1_0_2_000000C0_00000000_17_00000178_1_42578001_0_00_000000C0
0_1_1_0_1_000000C0_00000000_18_0000017C_1_FFFF8001_1_17_42578001
0_1_1_0_4_000000C3_00000000_19_00000180_1_00000042_1_18_FFFF8001
0_0_0_0_2_00000000_00000000_00_00000184_0_00000000_1_19_00000042
0_0_0_0_2_00000000_00000000_00_00000188_0_00000000_0_00_00000000

// ==== build.f ====
memPkg.sv
memPort_if.sv
storeFormatter.sv
dataRam.sv
loadAligner.sv
writebackRegister.sv
memStageTop.sv
tb_memStage.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --timescale 1ns/10ps --top-module tb_memStage \
		--Mdir obj_dir -f build.f
	-./obj_dir/Vtb_memStage > sim.log 2>&1
	@cat sim.log
	@if grep -q "^No errors$$" sim.log; then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
